// ==== flist.f ====
common/i2c_regs_pkg.sv
src/msg_mailbox.sv
byte_fifo/byte_fifo.sv
src/irq_gen.sv
src/reg_file_ctrl.sv
src/reg_read_mux.sv
src/i2c_peripheral_registers.sv
testbench/tb_i2c_peripheral_registers.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the register block testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -f flist.f \
  --top-module tb_i2c_peripheral_registers -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log
if grep -q "^No errors$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== testbench/tb_i2c_peripheral_registers.sv ====
`timescale 1ns/10ps

module tb_i2c_peripheral_registers;
  import i2c_regs_pkg::*;

  localparam int N_FIFO_PUSH   = 20;
  localparam int N_IRQ_ROUNDS  = 8;
  // planned bus accesses, irq rounds take about 40 each
  localparam int N_ACCESS      = 60 + 2 * (2 * N_FIFO_PUSH + 3 * FIFO_DEPTH + 2)
                                 + N_IRQ_ROUNDS * 40;
  localparam int WATCHDOG_NS   = 4 * 20 * N_ACCESS;

  logic      rst;  // clock
  logic      clk;  // async reset, active high
  apb_addr_t apb_waddr;
  apb_data_t apb_wdata;
  logic      apb_wren;
  apb_addr_t apb_raddr;
  logic      apb_rd_done;
  apb_data_t apb_rdata;
  i2c_addr_t i2c_addr;
  reg_byte_t i2c_wdata;
  logic      i2c_wren;
  logic      i2c_rd_done;
  reg_byte_t i2c_rdata;
  dev_addr_t i2c_dev_addr;
  logic      i2c_enable;
  reg_byte_t i2c_debounce;
  reg_byte_t i2c_scl_dly;
  reg_byte_t i2c_sda_dly;
  logic      i2c_irq;
  logic      apb_irq;

  // shadow copy of the register block
  dev_addr_t  m_dev;
  logic       m_enable;
  reg_byte_t  m_debounce;
  reg_byte_t  m_scl;
  reg_byte_t  m_sda;
  reg_byte_t  m_i2a_data;
  logic       m_i2a_pend;
  reg_byte_t  m_a2i_data;
  logic       m_a2i_pend;
  logic [2:0] m_i2c_en;
  reg_byte_t  m_i2c_sel_a;
  reg_byte_t  m_i2c_sel_b;
  logic [2:0] m_apb_en;
  reg_byte_t  m_apb_sel_a;
  reg_byte_t  m_apb_sel_b;
  reg_byte_t  q_i2a[$];
  reg_byte_t  q_a2i[$];

  logic [31:0] lcg_state = 32'd95;
  bit          checks_on = 1'b0;

  i2c_peripheral_registers i2c_peripheral_registers_i (
    .rst_i(rst), .clk_i(clk),
    .apb_waddr_i(apb_waddr), .apb_wdata_i(apb_wdata), .apb_wren_i(apb_wren),
    .apb_raddr_i(apb_raddr), .apb_rd_done_i(apb_rd_done), .apb_rdata_o(apb_rdata),
    .i2c_addr_i(i2c_addr), .i2c_wdata_i(i2c_wdata), .i2c_wren_i(i2c_wren),
    .i2c_rd_done_i(i2c_rd_done), .i2c_rdata_o(i2c_rdata),
    .i2c_dev_addr_o(i2c_dev_addr), .i2c_enable_o(i2c_enable),
    .i2c_debounce_o(i2c_debounce), .i2c_scl_dly_o(i2c_scl_dly), .i2c_sda_dly_o(i2c_sda_dly),
    .i2c_irq_o(i2c_irq), .apb_irq_o(apb_irq)
  );

  always #2 rst = ~rst;

  function automatic reg_byte_t rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];  // upper bits are the better ones
  endfunction

  function automatic apb_data_t rand_word();
    return {rand_byte(), rand_byte(), rand_byte(), rand_byte()};
  endfunction

  function automatic apb_addr_t word_addr(input i2c_addr_t idx);
    return {2'b00, idx, 2'b00};
  endfunction

  // entry count to fill-level code
  function automatic level_t level_of(input int n);
    if (n == 0)
      return 3'd0;
    else if (n <= 3)
      return 3'd1;
    else if (n <= 7)
      return 3'd2;
    else if (n <= 11)
      return 3'd3;
    else if (n <= 15)
      return 3'd4;
    return 3'd5;
  endfunction

  function automatic irq_status_t irq_rule(input logic [2:0] en, input reg_byte_t sel_a,
                                           input reg_byte_t sel_b, input level_t lvl_a,
                                           input level_t lvl_b, input logic pend);
    irq_status_t s;
    s[2] = en[2] & sel_a[lvl_a];
    s[1] = en[1] & sel_b[lvl_b];
    s[0] = en[0] & pend;
    return s;
  endfunction

  function automatic irq_status_t exp_status(input bit apb_side);
    if (apb_side)
      return irq_rule(m_apb_en, m_apb_sel_a, m_apb_sel_b, level_of(q_a2i.size()),
                      level_of(q_i2a.size()), m_i2a_pend);
    return irq_rule(m_i2c_en, m_i2c_sel_a, m_i2c_sel_b, level_of(q_i2a.size()),
                    level_of(q_a2i.size()), m_a2i_pend);
  endfunction

  function automatic reg_byte_t exp_read(input bit apb_side, input i2c_addr_t off);
    reg_byte_t r;
    r = 8'h00;
    case (off)
      REG_DEV_ADDR:      r = {1'b0, m_dev};
      REG_ENABLE:        r = {7'b0, m_enable};
      REG_DEBOUNCE:      r = m_debounce;
      REG_SCL_DLY:       r = m_scl;
      REG_SDA_DLY:       r = m_sda;
      REG_MSG_I2A:       r = m_i2a_data;
      REG_MSG_I2A_ST:    r = {7'b0, m_i2a_pend};
      REG_MSG_A2I:       r = m_a2i_data;
      REG_MSG_A2I_ST:    r = {7'b0, m_a2i_pend};
      REG_FIFO_I2A_RD:   if (apb_side && q_i2a.size() > 0) r = q_i2a[0];
      REG_FIFO_I2A_LVL,
      REG_FIFO_I2A_LVL2: r = {5'b0, level_of(q_i2a.size())};
      REG_FIFO_A2I_RD:   if (!apb_side && q_a2i.size() > 0) r = q_a2i[0];
      REG_FIFO_A2I_LVL,
      REG_FIFO_A2I_LVL2: r = {5'b0, level_of(q_a2i.size())};
      REG_IRQ_I2C_ST:    r = {5'b0, exp_status(1'b0)};
      REG_IRQ_I2C_EN:    r = {5'b0, m_i2c_en};
      REG_IRQ_I2C_SEL_A: r = m_i2c_sel_a;
      REG_IRQ_I2C_SEL_B: r = m_i2c_sel_b;
      REG_IRQ_APB_ST:    r = {5'b0, exp_status(1'b1)};
      REG_IRQ_APB_EN:    r = {5'b0, m_apb_en};
      REG_IRQ_APB_SEL_A: r = m_apb_sel_a;
      REG_IRQ_APB_SEL_B: r = m_apb_sel_b;
      default:           r = 8'h00;
    endcase
    return r;
  endfunction

  task automatic check_byte(input string name, input reg_byte_t got, input reg_byte_t want);
    if (got !== want) begin
      $display("mismatch %s got 0x%h exp 0x%h", name, got, want);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_word(input string name, input apb_data_t got, input apb_data_t want);
    if (got !== want) begin
      $display("mismatch %s got 0x%h exp 0x%h", name, got, want);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch %s got 0x%h exp 0x%h", name, got, want);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // interrupts are combinational, compare them mid-cycle
  always @(negedge rst) begin
    if (checks_on) begin
      check_irq("i2c_irq_o", i2c_irq, |exp_status(1'b0));
      check_irq("apb_irq_o", apb_irq, |exp_status(1'b1));
    end
  end

  task automatic step_cycle();
    @(posedge rst);
    #1;
  endtask

  task automatic check_cfg_outputs();
    check_byte("i2c_dev_addr_o", {1'b0, i2c_dev_addr}, {1'b0, m_dev});
    check_byte("i2c_enable_o", {7'b0, i2c_enable}, {7'b0, m_enable});
    check_byte("i2c_debounce_o", i2c_debounce, m_debounce);
    check_byte("i2c_scl_dly_o", i2c_scl_dly, m_scl);
    check_byte("i2c_sda_dly_o", i2c_sda_dly, m_sda);
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    apb_waddr = addr;
    apb_wdata = data;
    apb_wren  = 1'b1;
    step_cycle();
    apb_wren  = 1'b0;
    if (addr[11:10] == 2'b00) begin
      case (addr[9:2])
        REG_DEV_ADDR:      m_dev = data[6:0];
        REG_ENABLE:        m_enable = data[0];
        REG_DEBOUNCE:      m_debounce = data[7:0];
        REG_SCL_DLY:       m_scl = data[7:0];
        REG_SDA_DLY:       m_sda = data[7:0];
        REG_MSG_A2I: begin
          m_a2i_data = data[7:0];
          m_a2i_pend = 1'b1;
        end
        REG_FIFO_A2I_WR:   if (q_a2i.size() < 16) q_a2i.push_back(data[7:0]);
        REG_IRQ_APB_EN:    m_apb_en = data[2:0];
        REG_IRQ_APB_SEL_A: m_apb_sel_a = data[7:0];
        REG_IRQ_APB_SEL_B: m_apb_sel_b = data[7:0];
        default: ;
      endcase
    end
  endtask

  task automatic i2c_write(input i2c_addr_t off, input reg_byte_t data);
    i2c_addr  = off;
    i2c_wdata = data;
    i2c_wren  = 1'b1;
    step_cycle();
    i2c_wren  = 1'b0;
    case (off)
      REG_MSG_I2A: begin
        m_i2a_data = data;
        m_i2a_pend = 1'b1;
      end
      REG_FIFO_I2A_WR:   if (q_i2a.size() < 16) q_i2a.push_back(data);  // full drops it
      REG_IRQ_I2C_EN:    m_i2c_en = data[2:0];
      REG_IRQ_I2C_SEL_A: m_i2c_sel_a = data;
      REG_IRQ_I2C_SEL_B: m_i2c_sel_b = data;
      default: ;
    endcase
  endtask

  task automatic apb_read(input apb_addr_t addr, input logic done);
    reg_byte_t want;
    want = (addr[11:10] == 2'b00) ? exp_read(1'b1, addr[9:2]) : 8'h00;
    apb_raddr   = addr;
    apb_rd_done = done;
    step_cycle();
    apb_rd_done = 1'b0;
    check_word("apb_rdata_o", apb_rdata, {24'h0, want});
    if (done && addr[11:10] == 2'b00 && addr[1:0] == 2'b00) begin
      if (addr[9:2] == REG_MSG_I2A)
        m_i2a_pend = 1'b0;
      else if (addr[9:2] == REG_FIFO_I2A_RD && q_i2a.size() > 0)
        void'(q_i2a.pop_front());
    end
  endtask

  task automatic i2c_read(input i2c_addr_t off, input logic done);
    reg_byte_t want;
    want = exp_read(1'b0, off);
    i2c_addr    = off;
    i2c_rd_done = done;
    step_cycle();
    i2c_rd_done = 1'b0;
    check_byte("i2c_rdata_o", i2c_rdata, want);
    if (done && off == REG_MSG_A2I)
      m_a2i_pend = 1'b0;
    else if (done && off == REG_FIFO_A2I_RD && q_a2i.size() > 0)
      void'(q_a2i.pop_front());
  endtask

  // same offset on both ports in one cycle
  task automatic read_pair(input i2c_addr_t off);
    reg_byte_t want_apb;
    reg_byte_t want_i2c;
    want_apb  = exp_read(1'b1, off);
    want_i2c  = exp_read(1'b0, off);
    apb_raddr = word_addr(off);
    i2c_addr  = off;
    step_cycle();
    check_word("apb_rdata_o", apb_rdata, {24'h0, want_apb});
    check_byte("i2c_rdata_o", i2c_rdata, want_i2c);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    reg_byte_t rb;
    int        n_i2a;
    int        n_a2i;
    rst = 1'b0;
    clk = 1'b1;
    apb_waddr = '0;
    apb_wdata = '0;
    apb_wren = 1'b0;
    apb_raddr = '0;
    apb_rd_done = 1'b0;
    i2c_addr = '0;
    i2c_wdata = '0;
    i2c_wren = 1'b0;
    i2c_rd_done = 1'b0;
    m_dev = 7'h6F;
    m_enable = 1'b0;
    m_debounce = 8'd20;
    m_scl = 8'd20;
    m_sda = 8'd8;
    m_i2a_data = 8'h00;
    m_i2a_pend = 1'b0;
    m_a2i_data = 8'h00;
    m_a2i_pend = 1'b0;
    m_i2c_en = 3'b000;
    m_i2c_sel_a = 8'h00;
    m_i2c_sel_b = 8'h00;
    m_apb_en = 3'b000;
    m_apb_sel_a = 8'h00;
    m_apb_sel_b = 8'h00;
    repeat (3) @(posedge rst);
    #1;
    clk = 1'b0;
    checks_on = 1'b1;

    // reset values
    check_word("apb_rdata_o", apb_rdata, 32'h0);
    check_byte("i2c_rdata_o", i2c_rdata, 8'h00);
    check_irq("i2c_irq_o", i2c_irq, 1'b0);
    check_irq("apb_irq_o", apb_irq, 1'b0);
    check_cfg_outputs();
    for (int o = 0; o < 5; o++)
      read_pair(i2c_addr_t'(o));

    // configuration, good and ignored writes
    for (int o = 0; o < 5; o++)
      apb_write(word_addr(i2c_addr_t'(o)), rand_word());
    check_cfg_outputs();
    for (int o = 0; o < 5; o++)
      read_pair(i2c_addr_t'(o));
    for (int o = 0; o < 5; o++)
      apb_write({2'(o % 3 + 1), i2c_addr_t'(o), 2'b00}, rand_word());  // out of range
    for (int o = 0; o < 5; o++)
      i2c_write(i2c_addr_t'(o), rand_byte());  // apb-owned
    check_cfg_outputs();
    for (int o = 0; o < 5; o++)
      read_pair(i2c_addr_t'(o));
    apb_read({2'b10, REG_DEBOUNCE, 2'b00}, 1'b0);

    // mailboxes both ways
    i2c_write(REG_MSG_I2A, rand_byte());
    read_pair(REG_MSG_I2A_ST);
    apb_read({2'b00, REG_MSG_I2A, 2'b01}, 1'b1);  // unaligned, not consumed
    apb_read({2'b01, REG_MSG_I2A, 2'b00}, 1'b1);  // out of range, not consumed
    read_pair(REG_MSG_I2A_ST);
    apb_read(word_addr(REG_MSG_I2A), 1'b1);
    read_pair(REG_MSG_I2A_ST);
    apb_write(word_addr(REG_MSG_A2I), rand_word());
    read_pair(REG_MSG_A2I_ST);
    i2c_read(REG_MSG_A2I, 1'b1);
    read_pair(REG_MSG_A2I_ST);

    // fifo i2c to apb, last 4 pushes overflow
    for (int i = 0; i < N_FIFO_PUSH; i++) begin
      i2c_write(REG_FIFO_I2A_WR, rand_byte());
      read_pair(REG_FIFO_I2A_LVL);
    end
    read_pair(REG_FIFO_I2A_WR);
    for (int i = 0; i < 16; i++) begin
      read_pair(REG_FIFO_I2A_RD);
      apb_read(word_addr(REG_FIFO_I2A_RD), 1'b1);
      read_pair(REG_FIFO_I2A_LVL2);
    end

    // fifo apb to i2c
    for (int i = 0; i < N_FIFO_PUSH; i++) begin
      apb_write(word_addr(REG_FIFO_A2I_WR), rand_word());
      read_pair(REG_FIFO_A2I_LVL);
    end
    read_pair(REG_FIFO_A2I_WR);
    for (int i = 0; i < 16; i++) begin
      read_pair(REG_FIFO_A2I_RD);
      i2c_read(REG_FIFO_A2I_RD, 1'b1);
      read_pair(REG_FIFO_A2I_LVL2);
    end

    // interrupts with random enables and level selects
    for (int r = 0; r < N_IRQ_ROUNDS; r++) begin
      i2c_write(REG_IRQ_I2C_EN, rand_byte());
      i2c_write(REG_IRQ_I2C_SEL_A, rand_byte());
      i2c_write(REG_IRQ_I2C_SEL_B, rand_byte());
      apb_write(word_addr(REG_IRQ_APB_EN), rand_word());
      apb_write(word_addr(REG_IRQ_APB_SEL_A), rand_word());
      apb_write(word_addr(REG_IRQ_APB_SEL_B), rand_word());
      rb = rand_byte();
      n_i2a = int'(rb[2:0]);
      n_a2i = int'(rb[6:4]);
      for (int k = 0; k < n_i2a; k++)
        i2c_write(REG_FIFO_I2A_WR, rand_byte());
      for (int k = 0; k < n_a2i; k++)
        apb_write(word_addr(REG_FIFO_A2I_WR), rand_word());
      if (r % 2 == 1)
        i2c_write(REG_MSG_I2A, rand_byte());
      else
        apb_write(word_addr(REG_MSG_A2I), rand_word());
      read_pair(REG_IRQ_I2C_ST);
      read_pair(REG_IRQ_APB_ST);
      read_pair(REG_IRQ_I2C_SEL_A);
      read_pair(REG_IRQ_APB_EN);
      for (int k = 0; k < int'(rb[3:2]); k++) begin
        if (q_i2a.size() > 0)
          apb_read(word_addr(REG_FIFO_I2A_RD), 1'b1);
        if (q_a2i.size() > 0)
          i2c_read(REG_FIFO_A2I_RD, 1'b1);
      end
      if (r % 4 == 3) begin
        apb_read(word_addr(REG_MSG_I2A), 1'b1);
        i2c_read(REG_MSG_A2I, 1'b1);
      end
      read_pair(REG_IRQ_I2C_ST);
      read_pair(REG_IRQ_APB_ST);
    end

    $display("No errors");
    $finish;
  end

endmodule

// ==== src/i2c_peripheral_registers.sv ====
`timescale 1ns/10ps

module i2c_peripheral_registers (
  input  logic                    rst_i,
  input  logic                    clk_i,
  input  i2c_regs_pkg::apb_addr_t apb_waddr_i,
  input  i2c_regs_pkg::apb_data_t apb_wdata_i,
  input  logic                    apb_wren_i,
  input  i2c_regs_pkg::apb_addr_t apb_raddr_i,
  input  logic                    apb_rd_done_i,
  output i2c_regs_pkg::apb_data_t apb_rdata_o,
  input  i2c_regs_pkg::i2c_addr_t i2c_addr_i,
  input  i2c_regs_pkg::reg_byte_t i2c_wdata_i,
  input  logic                    i2c_wren_i,
  input  logic                    i2c_rd_done_i,
  output i2c_regs_pkg::reg_byte_t i2c_rdata_o,
  output i2c_regs_pkg::dev_addr_t i2c_dev_addr_o,
  output logic                    i2c_enable_o,
  output i2c_regs_pkg::reg_byte_t i2c_debounce_o,
  output i2c_regs_pkg::reg_byte_t i2c_scl_dly_o,
  output i2c_regs_pkg::reg_byte_t i2c_sda_dly_o,
  output logic                    i2c_irq_o,
  output logic                    apb_irq_o
);
  import i2c_regs_pkg::*;

  logic [2:0]  irq_i2c_en;
  logic [2:0]  irq_apb_en;
  reg_byte_t   irq_i2c_sel_a;
  reg_byte_t   irq_i2c_sel_b;
  reg_byte_t   irq_apb_sel_a;
  reg_byte_t   irq_apb_sel_b;
  logic        msg_i2a_set;
  logic        msg_i2a_clr;
  logic        msg_a2i_set;
  logic        msg_a2i_clr;
  logic        fifo_i2a_push;
  logic        fifo_i2a_pop;
  logic        fifo_a2i_push;
  logic        fifo_a2i_pop;
  reg_byte_t   msg_i2a_data;
  logic        msg_i2a_pending;
  reg_byte_t   msg_a2i_data;
  logic        msg_a2i_pending;
  reg_byte_t   fifo_i2a_head;
  level_t      fifo_i2a_level;
  reg_byte_t   fifo_a2i_head;
  level_t      fifo_a2i_level;
  irq_status_t irq_i2c_status;
  irq_status_t irq_apb_status;

  reg_file_ctrl reg_file_ctrl_i (
    .rst_i(rst_i), .clk_i(clk_i),
    .apb_waddr_i(apb_waddr_i), .apb_wdata_i(apb_wdata_i), .apb_wren_i(apb_wren_i),
    .apb_raddr_i(apb_raddr_i), .apb_rd_done_i(apb_rd_done_i),
    .i2c_addr_i(i2c_addr_i), .i2c_wdata_i(i2c_wdata_i), .i2c_wren_i(i2c_wren_i),
    .i2c_rd_done_i(i2c_rd_done_i),
    .dev_addr_o(i2c_dev_addr_o), .enable_o(i2c_enable_o), .debounce_o(i2c_debounce_o),
    .scl_dly_o(i2c_scl_dly_o), .sda_dly_o(i2c_sda_dly_o),
    .irq_i2c_en_o(irq_i2c_en), .irq_apb_en_o(irq_apb_en),
    .irq_i2c_sel_a_o(irq_i2c_sel_a), .irq_i2c_sel_b_o(irq_i2c_sel_b),
    .irq_apb_sel_a_o(irq_apb_sel_a), .irq_apb_sel_b_o(irq_apb_sel_b),
    .msg_i2a_set_o(msg_i2a_set), .msg_i2a_clr_o(msg_i2a_clr),
    .msg_a2i_set_o(msg_a2i_set), .msg_a2i_clr_o(msg_a2i_clr),
    .fifo_i2a_push_o(fifo_i2a_push), .fifo_i2a_pop_o(fifo_i2a_pop),
    .fifo_a2i_push_o(fifo_a2i_push), .fifo_a2i_pop_o(fifo_a2i_pop)
  );

  // i2c to apb
  msg_mailbox msg_i2a_i (
    .rst_i(rst_i), .clk_i(clk_i), .set_i(msg_i2a_set), .data_i(i2c_wdata_i),
    .clr_i(msg_i2a_clr), .data_o(msg_i2a_data), .pending_o(msg_i2a_pending)
  );

  byte_fifo fifo_i2a_i (
    .rst_i(rst_i), .clk_i(clk_i), .push_i(fifo_i2a_push), .data_i(i2c_wdata_i),
    .pop_i(fifo_i2a_pop), .head_o(fifo_i2a_head), .level_o(fifo_i2a_level)
  );

  // apb to i2c, low byte of the bus word
  msg_mailbox msg_a2i_i (
    .rst_i(rst_i), .clk_i(clk_i), .set_i(msg_a2i_set), .data_i(apb_wdata_i[7:0]),
    .clr_i(msg_a2i_clr), .data_o(msg_a2i_data), .pending_o(msg_a2i_pending)
  );

  byte_fifo fifo_a2i_i (
    .rst_i(rst_i), .clk_i(clk_i), .push_i(fifo_a2i_push), .data_i(apb_wdata_i[7:0]),
    .pop_i(fifo_a2i_pop), .head_o(fifo_a2i_head), .level_o(fifo_a2i_level)
  );

  irq_gen irq_i2c_i (
    .en_i(irq_i2c_en), .sel_a_i(irq_i2c_sel_a), .sel_b_i(irq_i2c_sel_b),
    .level_a_i(fifo_i2a_level), .level_b_i(fifo_a2i_level),
    .msg_pending_i(msg_a2i_pending), .status_o(irq_i2c_status), .irq_o(i2c_irq_o)
  );

  irq_gen irq_apb_i (
    .en_i(irq_apb_en), .sel_a_i(irq_apb_sel_a), .sel_b_i(irq_apb_sel_b),
    .level_a_i(fifo_a2i_level), .level_b_i(fifo_i2a_level),
    .msg_pending_i(msg_i2a_pending), .status_o(irq_apb_status), .irq_o(apb_irq_o)
  );

  reg_read_mux reg_read_mux_i (
    .rst_i(rst_i), .clk_i(clk_i),
    .apb_raddr_i(apb_raddr_i), .i2c_addr_i(i2c_addr_i),
    .dev_addr_i(i2c_dev_addr_o), .enable_i(i2c_enable_o), .debounce_i(i2c_debounce_o),
    .scl_dly_i(i2c_scl_dly_o), .sda_dly_i(i2c_sda_dly_o),
    .msg_i2a_data_i(msg_i2a_data), .msg_i2a_pending_i(msg_i2a_pending),
    .msg_a2i_data_i(msg_a2i_data), .msg_a2i_pending_i(msg_a2i_pending),
    .fifo_i2a_head_i(fifo_i2a_head), .fifo_i2a_level_i(fifo_i2a_level),
    .fifo_a2i_head_i(fifo_a2i_head), .fifo_a2i_level_i(fifo_a2i_level),
    .irq_i2c_status_i(irq_i2c_status), .irq_i2c_en_i(irq_i2c_en),
    .irq_i2c_sel_a_i(irq_i2c_sel_a), .irq_i2c_sel_b_i(irq_i2c_sel_b),
    .irq_apb_status_i(irq_apb_status), .irq_apb_en_i(irq_apb_en),
    .irq_apb_sel_a_i(irq_apb_sel_a), .irq_apb_sel_b_i(irq_apb_sel_b),
    .apb_rdata_o(apb_rdata_o), .i2c_rdata_o(i2c_rdata_o)
  );

endmodule

// ==== src/reg_read_mux.sv ====
`timescale 1ns/10ps

module reg_read_mux (
  input  logic                      rst_i,
  input  logic                      clk_i,
  input  i2c_regs_pkg::apb_addr_t   apb_raddr_i,
  input  i2c_regs_pkg::i2c_addr_t   i2c_addr_i,
  input  i2c_regs_pkg::dev_addr_t   dev_addr_i,
  input  logic                      enable_i,
  input  i2c_regs_pkg::reg_byte_t   debounce_i,
  input  i2c_regs_pkg::reg_byte_t   scl_dly_i,
  input  i2c_regs_pkg::reg_byte_t   sda_dly_i,
  input  i2c_regs_pkg::reg_byte_t   msg_i2a_data_i,
  input  logic                      msg_i2a_pending_i,
  input  i2c_regs_pkg::reg_byte_t   msg_a2i_data_i,
  input  logic                      msg_a2i_pending_i,
  input  i2c_regs_pkg::reg_byte_t   fifo_i2a_head_i,
  input  i2c_regs_pkg::level_t      fifo_i2a_level_i,
  input  i2c_regs_pkg::reg_byte_t   fifo_a2i_head_i,
  input  i2c_regs_pkg::level_t      fifo_a2i_level_i,
  input  i2c_regs_pkg::irq_status_t irq_i2c_status_i,
  input  logic [2:0]                irq_i2c_en_i,
  input  i2c_regs_pkg::reg_byte_t   irq_i2c_sel_a_i,
  input  i2c_regs_pkg::reg_byte_t   irq_i2c_sel_b_i,
  input  i2c_regs_pkg::irq_status_t irq_apb_status_i,
  input  logic [2:0]                irq_apb_en_i,
  input  i2c_regs_pkg::reg_byte_t   irq_apb_sel_a_i,
  input  i2c_regs_pkg::reg_byte_t   irq_apb_sel_b_i,
  output i2c_regs_pkg::apb_data_t   apb_rdata_o,
  output i2c_regs_pkg::reg_byte_t   i2c_rdata_o
);
  import i2c_regs_pkg::*;

  reg_byte_t apb_sel;
  reg_byte_t i2c_sel;

  // shared register map, fifo read ports only answer their own side
  function automatic reg_byte_t rd_sel(input i2c_addr_t off, input logic apb_side);
    case (off)
      REG_DEV_ADDR:      return {1'b0, dev_addr_i};
      REG_ENABLE:        return {7'b0, enable_i};
      REG_DEBOUNCE:      return debounce_i;
      REG_SCL_DLY:       return scl_dly_i;
      REG_SDA_DLY:       return sda_dly_i;
      REG_MSG_I2A:       return msg_i2a_data_i;
      REG_MSG_I2A_ST:    return {7'b0, msg_i2a_pending_i};
      REG_MSG_A2I:       return msg_a2i_data_i;
      REG_MSG_A2I_ST:    return {7'b0, msg_a2i_pending_i};
      REG_FIFO_I2A_RD:   return apb_side ? fifo_i2a_head_i : 8'h00;
      REG_FIFO_I2A_LVL,
      REG_FIFO_I2A_LVL2: return {5'b0, fifo_i2a_level_i};
      REG_FIFO_A2I_RD:   return apb_side ? 8'h00 : fifo_a2i_head_i;
      REG_FIFO_A2I_LVL,
      REG_FIFO_A2I_LVL2: return {5'b0, fifo_a2i_level_i};
      REG_IRQ_I2C_ST:    return {5'b0, irq_i2c_status_i};
      REG_IRQ_I2C_EN:    return {5'b0, irq_i2c_en_i};
      REG_IRQ_I2C_SEL_A: return irq_i2c_sel_a_i;
      REG_IRQ_I2C_SEL_B: return irq_i2c_sel_b_i;
      REG_IRQ_APB_ST:    return {5'b0, irq_apb_status_i};
      REG_IRQ_APB_EN:    return {5'b0, irq_apb_en_i};
      REG_IRQ_APB_SEL_A: return irq_apb_sel_a_i;
      REG_IRQ_APB_SEL_B: return irq_apb_sel_b_i;
      default:           return 8'h00;  // write-only fifo ports land here too
    endcase
  endfunction

  always_comb begin
    apb_sel = (apb_raddr_i[11:10] == 2'b00) ? rd_sel(apb_raddr_i[9:2], 1'b1) : 8'h00;
    i2c_sel = rd_sel(i2c_addr_i, 1'b0);
  end

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      apb_rdata_o <= '0;
      i2c_rdata_o <= '0;
    end else begin
      apb_rdata_o <= {24'b0, apb_sel};
      i2c_rdata_o <= i2c_sel;
    end
  end

endmodule

// ==== src/reg_file_ctrl.sv ====
`timescale 1ns/10ps

module reg_file_ctrl (
  input  logic                    rst_i,
  input  logic                    clk_i,
  input  i2c_regs_pkg::apb_addr_t apb_waddr_i,
  input  i2c_regs_pkg::apb_data_t apb_wdata_i,
  input  logic                    apb_wren_i,
  input  i2c_regs_pkg::apb_addr_t apb_raddr_i,
  input  logic                    apb_rd_done_i,
  input  i2c_regs_pkg::i2c_addr_t i2c_addr_i,
  input  i2c_regs_pkg::reg_byte_t i2c_wdata_i,
  input  logic                    i2c_wren_i,
  input  logic                    i2c_rd_done_i,
  output i2c_regs_pkg::dev_addr_t dev_addr_o,
  output logic                    enable_o,
  output i2c_regs_pkg::reg_byte_t debounce_o,
  output i2c_regs_pkg::reg_byte_t scl_dly_o,
  output i2c_regs_pkg::reg_byte_t sda_dly_o,
  output logic [2:0]              irq_i2c_en_o,
  output logic [2:0]              irq_apb_en_o,
  output i2c_regs_pkg::reg_byte_t irq_i2c_sel_a_o,
  output i2c_regs_pkg::reg_byte_t irq_i2c_sel_b_o,
  output i2c_regs_pkg::reg_byte_t irq_apb_sel_a_o,
  output i2c_regs_pkg::reg_byte_t irq_apb_sel_b_o,
  output logic                    msg_i2a_set_o,
  output logic                    msg_i2a_clr_o,
  output logic                    msg_a2i_set_o,
  output logic                    msg_a2i_clr_o,
  output logic                    fifo_i2a_push_o,
  output logic                    fifo_i2a_pop_o,
  output logic                    fifo_a2i_push_o,
  output logic                    fifo_a2i_pop_o
);
  import i2c_regs_pkg::*;

  logic      apb_wr;
  logic      apb_rd_ok;
  i2c_addr_t apb_widx;
  i2c_addr_t apb_ridx;

  assign apb_wr    = apb_wren_i && (apb_waddr_i[11:10] == 2'b00);
  assign apb_rd_ok = apb_rd_done_i && (apb_raddr_i[11:10] == 2'b00)
                     && (apb_raddr_i[1:0] == 2'b00);  // consumed only on word-aligned reads
  assign apb_widx  = apb_waddr_i[9:2];
  assign apb_ridx  = apb_raddr_i[9:2];

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      dev_addr_o      <= DEF_DEV_ADDR;
      enable_o        <= 1'b0;
      debounce_o      <= DEF_DEBOUNCE;
      scl_dly_o       <= DEF_SCL_DLY;
      sda_dly_o       <= DEF_SDA_DLY;
      irq_i2c_en_o    <= '0;
      irq_i2c_sel_a_o <= '0;
      irq_i2c_sel_b_o <= '0;
      irq_apb_en_o    <= '0;
      irq_apb_sel_a_o <= '0;
      irq_apb_sel_b_o <= '0;
    end else begin
      if (apb_wr) begin
        case (apb_widx)
          REG_DEV_ADDR:      dev_addr_o      <= apb_wdata_i[6:0];
          REG_ENABLE:        enable_o        <= apb_wdata_i[0];
          REG_DEBOUNCE:      debounce_o      <= apb_wdata_i[7:0];
          REG_SCL_DLY:       scl_dly_o       <= apb_wdata_i[7:0];
          REG_SDA_DLY:       sda_dly_o       <= apb_wdata_i[7:0];
          REG_IRQ_APB_EN:    irq_apb_en_o    <= apb_wdata_i[2:0];
          REG_IRQ_APB_SEL_A: irq_apb_sel_a_o <= apb_wdata_i[7:0];
          REG_IRQ_APB_SEL_B: irq_apb_sel_b_o <= apb_wdata_i[7:0];
          default: ;  // i2c-owned or unknown
        endcase
      end
      if (i2c_wren_i) begin
        case (i2c_addr_i)
          REG_IRQ_I2C_EN:    irq_i2c_en_o    <= i2c_wdata_i[2:0];
          REG_IRQ_I2C_SEL_A: irq_i2c_sel_a_o <= i2c_wdata_i;
          REG_IRQ_I2C_SEL_B: irq_i2c_sel_b_o <= i2c_wdata_i;
          default: ;
        endcase
      end
    end
  end

  // mailbox strobes
  assign msg_i2a_set_o = i2c_wren_i && (i2c_addr_i == REG_MSG_I2A);
  assign msg_i2a_clr_o = apb_rd_ok && (apb_ridx == REG_MSG_I2A);
  assign msg_a2i_set_o = apb_wr && (apb_widx == REG_MSG_A2I);
  assign msg_a2i_clr_o = i2c_rd_done_i && (i2c_addr_i == REG_MSG_A2I);

  // fifo strobes, pops follow the read address
  assign fifo_i2a_push_o = i2c_wren_i && (i2c_addr_i == REG_FIFO_I2A_WR);
  assign fifo_i2a_pop_o  = apb_rd_ok && (apb_ridx == REG_FIFO_I2A_RD);
  assign fifo_a2i_push_o = apb_wr && (apb_widx == REG_FIFO_A2I_WR);
  assign fifo_a2i_pop_o  = i2c_rd_done_i && (i2c_addr_i == REG_FIFO_A2I_RD);

endmodule

// ==== src/irq_gen.sv ====
`timescale 1ns/10ps

module irq_gen (
  input  logic [2:0]               en_i,
  input  i2c_regs_pkg::reg_byte_t   sel_a_i,
  input  i2c_regs_pkg::reg_byte_t   sel_b_i,
  input  i2c_regs_pkg::level_t      level_a_i,
  input  i2c_regs_pkg::level_t      level_b_i,
  input  logic                     msg_pending_i,
  output i2c_regs_pkg::irq_status_t status_o,
  output logic                     irq_o
);
  import i2c_regs_pkg::*;

  // each select byte holds one enable bit per level code
  assign status_o[2] = en_i[2] && sel_a_i[level_a_i];
  assign status_o[1] = en_i[1] && sel_b_i[level_b_i];
  assign status_o[0] = en_i[0] && msg_pending_i;

  assign irq_o = |status_o;

endmodule

// ==== byte_fifo/byte_fifo.sv ====
`timescale 1ns/10ps

module byte_fifo (
  input  logic                   rst_i,
  input  logic                   clk_i,
  input  logic                   push_i,
  input  i2c_regs_pkg::reg_byte_t data_i,
  input  logic                   pop_i,
  output i2c_regs_pkg::reg_byte_t head_o,
  output i2c_regs_pkg::level_t    level_o
);
  import i2c_regs_pkg::*;

  typedef logic [FIFO_PTR_W:0] cnt_t;

  reg_byte_t               mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]   wr_ptr;
  logic [FIFO_PTR_W-1:0]   rd_ptr;
  cnt_t                    count;
  logic                    full;
  logic                    empty;
  logic                    do_push;
  logic                    do_pop;

  assign full    = (count == cnt_t'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_pop  = pop_i && !empty;
  assign do_push = push_i && (!full || do_pop);  // full slot frees up on a same-cycle pop

  assign head_o = mem[rd_ptr];  // first-word fall-through

  always_ff @(posedge rst_i) begin
    if (do_push)
      mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // count to level code, upper two count bits pick the quarter
  always_comb begin
    if (full) begin
      level_o = LVL_FULL;
    end else begin
      case (count[FIFO_PTR_W-1 -: 2])
        2'd0:    level_o = empty ? LVL_EMPTY : LVL_LOW;
        2'd1:    level_o = LVL_QUARTER;
        2'd2:    level_o = LVL_HALF;
        default: level_o = LVL_HIGH;
      endcase
    end
  end

endmodule

// ==== src/msg_mailbox.sv ====
`timescale 1ns/10ps

module msg_mailbox (
  input  logic                   rst_i,
  input  logic                   clk_i,
  input  logic                   set_i,
  input  i2c_regs_pkg::reg_byte_t data_i,
  input  logic                   clr_i,
  output i2c_regs_pkg::reg_byte_t data_o,
  output logic                   pending_o
);
  import i2c_regs_pkg::*;

  always_ff @(posedge rst_i or posedge clk_i) begin
    if (clk_i) begin
      data_o    <= '0;
      pending_o <= 1'b0;
    end else if (set_i) begin
      data_o    <= data_i;
      pending_o <= 1'b1;  // a new message beats a same-cycle clear
    end else if (clr_i) begin
      pending_o <= 1'b0;
    end
  end

endmodule

// ==== common/i2c_regs_pkg.sv ====
package i2c_regs_pkg;

  typedef logic [7:0]  reg_byte_t;
  typedef logic [6:0]  dev_addr_t;
  typedef logic [7:0]  i2c_addr_t;
  typedef logic [11:0] apb_addr_t;  // [11:10] zero, [9:2] index, [1:0] byte
  typedef logic [31:0] apb_data_t;
  typedef logic [2:0]  level_t;
  typedef logic [2:0]  irq_status_t;  // {own fifo, other fifo, mailbox}

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = 4;

  // configuration
  localparam i2c_addr_t REG_DEV_ADDR      = 8'h00;
  localparam i2c_addr_t REG_ENABLE        = 8'h01;
  localparam i2c_addr_t REG_DEBOUNCE      = 8'h02;
  localparam i2c_addr_t REG_SCL_DLY       = 8'h03;
  localparam i2c_addr_t REG_SDA_DLY       = 8'h04;

  // mailboxes
  localparam i2c_addr_t REG_MSG_I2A       = 8'h10;
  localparam i2c_addr_t REG_MSG_I2A_ST    = 8'h11;
  localparam i2c_addr_t REG_MSG_A2I       = 8'h12;
  localparam i2c_addr_t REG_MSG_A2I_ST    = 8'h13;

  // fifos
  localparam i2c_addr_t REG_FIFO_I2A_WR   = 8'h20;
  localparam i2c_addr_t REG_FIFO_I2A_RD   = 8'h21;
  localparam i2c_addr_t REG_FIFO_I2A_LVL  = 8'h23;
  localparam i2c_addr_t REG_FIFO_I2A_LVL2 = 8'h24;
  localparam i2c_addr_t REG_FIFO_A2I_WR   = 8'h30;
  localparam i2c_addr_t REG_FIFO_A2I_RD   = 8'h31;
  localparam i2c_addr_t REG_FIFO_A2I_LVL  = 8'h33;
  localparam i2c_addr_t REG_FIFO_A2I_LVL2 = 8'h34;

  // interrupts
  localparam i2c_addr_t REG_IRQ_I2C_ST    = 8'h40;
  localparam i2c_addr_t REG_IRQ_I2C_EN    = 8'h41;
  localparam i2c_addr_t REG_IRQ_I2C_SEL_A = 8'h42;
  localparam i2c_addr_t REG_IRQ_I2C_SEL_B = 8'h43;
  localparam i2c_addr_t REG_IRQ_APB_ST    = 8'h50;
  localparam i2c_addr_t REG_IRQ_APB_EN    = 8'h51;
  localparam i2c_addr_t REG_IRQ_APB_SEL_A = 8'h52;
  localparam i2c_addr_t REG_IRQ_APB_SEL_B = 8'h53;

  localparam dev_addr_t DEF_DEV_ADDR = 7'h6F;
  localparam reg_byte_t DEF_DEBOUNCE = 8'd20;
  localparam reg_byte_t DEF_SCL_DLY  = 8'd20;
  localparam reg_byte_t DEF_SDA_DLY  = 8'd8;

  // fill level codes, 6 and 7 unused
  localparam level_t LVL_EMPTY   = 3'd0;
  localparam level_t LVL_LOW     = 3'd1;  // 1..3 entries
  localparam level_t LVL_QUARTER = 3'd2;  // 4..7
  localparam level_t LVL_HALF    = 3'd3;  // 8..11
  localparam level_t LVL_HIGH    = 3'd4;  // 12..15
  localparam level_t LVL_FULL    = 3'd5;

endpackage
